//--- filelist.f
+incdir+sim
logic/dmem_pkg.sv
logic/wb_sram.sv
logic/data_memory_selector.sv
logic/data_memory_subsystem.sv
sim/tb_data_memory_subsystem.sv

//--- Bender.yml
package:
  name: data_memory_subsystem

sources:
  - logic/dmem_pkg.sv
  - logic/wb_sram.sv
  - logic/data_memory_selector.sv
  - logic/data_memory_subsystem.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_data_memory_subsystem.sv

//--- sim/tb_tasks.svh
//////////////////////////////
// Helpers
//////////////////////////////

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic dmem_pkg::wb_req_t make_req(input logic we, input logic [31:0] adr,
                                               input logic [31:0] dat, input logic [3:0] sel);
    dmem_pkg::wb_req_t req;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = dat;
    req.sel = sel;
    return req;
endfunction

task automatic report_problem(input string msg);
    $display("Error in %s: %s", current_test, msg);
    error_count++;
endtask

task automatic check_rsp(input dmem_pkg::wb_rsp_t exp, input dmem_pkg::wb_rsp_t act);
    if (exp.ack !== act.ack || exp.err !== act.err) begin
        $display("Fail %s: expected ack=%0b err=%0b, actual ack=%0b err=%0b",
                 current_test, exp.ack, exp.err, act.ack, act.err);
        error_count++;
    end
endtask

task automatic check_data(input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
        $display("Fail %s: expected data 0x%08h, actual data 0x%08h", current_test, exp, act);
        error_count++;
    end
endtask

task automatic start_test(input string name);
    current_test         = name;
    test_errors_at_start = error_count;
endtask

task automatic end_test();
    if (error_count == test_errors_at_start) begin
        tests_passed++;
        $display("%-20s passed", current_test);
    end else begin
        tests_failed++;
        $display("%-20s failed with %0d errors", current_test,
                 error_count - test_errors_at_start);
    end
endtask

//////////////////////////////
// Bus transactions
//////////////////////////////

// Drive one cycle, then check the answer to the previous cycle
task automatic bus_cycle(input dmem_pkg::wb_req_t req);
    dmem_pkg::wb_rsp_t rsp;
    @(posedge clk);
    core_req <= req;
    @(negedge clk);
    rsp = core_rsp;
    if (pend_ack && rsp.ack !== 1'b1) begin
        report_problem("ack missing one cycle after an accepted request");
    end else if (!pend_ack && rsp.ack !== 1'b0) begin
        report_problem("ack seen one cycle after an idle cycle");
    end else begin
        check_rsp(exp_rsp, rsp);
        if (pend_ack && pend_check_dat) begin
            check_data(exp_rsp.dat, rsp.dat);
        end
    end
    predict(req);
endtask

task automatic single_access(input logic we, input logic [31:0] adr,
                             input logic [31:0] dat, input logic [3:0] sel);
    bus_cycle(make_req(we, adr, dat, sel));
    bus_cycle('0);
endtask

// Back-to-back strobes and one idle cycle to collect the last ack
task automatic burst_access(input dmem_pkg::wb_req_t reqs[$]);
    foreach (reqs[i]) begin
        bus_cycle(reqs[i]);
    end
    bus_cycle('0);
endtask

//////////////////////////////
// Directed tests
//////////////////////////////

task automatic region0_read_write();
    start_test("region0_rw");
    single_access(1'b1, R0_BASE + 32'h0, 32'h1122_3344, 4'hF);
    single_access(1'b1, R0_BASE + 32'h4, 32'hA5A5_5A5A, 4'hF);
    single_access(1'b1, R0_BASE + 32'h8, 32'h0F0F_F0F0, 4'hF);
    single_access(1'b1, R0_BASE + 32'h0, 32'hFFFF_FF99, 4'b0001);
    single_access(1'b1, R0_BASE + 32'h4, 32'h00BE_EF00, 4'b0110);
    single_access(1'b1, R0_BASE + 32'h8, 32'h7700_0000, 4'b1000);
    single_access(1'b1, R0_BASE + 32'h0, 32'hCAFE_0000, 4'b1100);
    for (int i = 0; i < 3; i++) begin
        single_access(1'b0, R0_BASE + 32'(i * 4), '0, 4'hF);
    end
    end_test();
endtask

task automatic region_independence();
    dmem_pkg::wb_req_t reqs[$];
    logic [31:0]       offs [3] = '{32'h000, 32'h010, 32'hFFC};
    start_test("region_alias");
    foreach (offs[i]) begin
        reqs.push_back(make_req(1'b1, R0_BASE + offs[i], 32'h0A00_0000 | offs[i], 4'hF));
        reqs.push_back(make_req(1'b1, R1_BASE + offs[i], 32'h1B00_0000 | offs[i], 4'hF));
    end
    reqs.push_back(make_req(1'b1, R1_BASE + R1_SIZE - 4, 32'h1B1A_57ED, 4'hF));
    burst_access(reqs);
    reqs.delete();
    foreach (offs[i]) begin
        reqs.push_back(make_req(1'b0, R0_BASE + offs[i], '0, 4'hF));
        reqs.push_back(make_req(1'b0, R1_BASE + offs[i], '0, 4'hF));
    end
    reqs.push_back(make_req(1'b0, R1_BASE + R1_SIZE - 4, '0, 4'hF));
    burst_access(reqs);
    end_test();
endtask

task automatic unmapped_access();
    dmem_pkg::wb_req_t reqs[$];
    logic [31:0]       addrs [5] = '{32'h7FFF_FFFC, 32'h8000_1000, 32'h8000_8000,
                                     32'h8000_FFFC, 32'h8002_0000};
    start_test("unmapped");
    foreach (addrs[i]) begin
        reqs.push_back(make_req(1'b1, addrs[i], 32'hBAD0_0000 | 32'(i), 4'hF));
        reqs.push_back(make_req(1'b0, addrs[i], '0, 4'hF));
    end
    burst_access(reqs);
    reqs.delete();
    // Words an aliasing write would have hit
    reqs.push_back(make_req(1'b0, R0_BASE, '0, 4'hF));
    reqs.push_back(make_req(1'b0, R0_BASE + R0_SIZE - 4, '0, 4'hF));
    reqs.push_back(make_req(1'b0, R1_BASE, '0, 4'hF));
    reqs.push_back(make_req(1'b0, R1_BASE + R1_SIZE - 4, '0, 4'hF));
    burst_access(reqs);
    end_test();
endtask

task automatic range_boundaries();
    dmem_pkg::wb_req_t reqs[$];
    logic [31:0]       addrs [8];
    addrs = '{R0_BASE, R0_BASE + R0_SIZE - 4, R0_BASE - 4, R0_BASE + R0_SIZE,
              R1_BASE, R1_BASE + R1_SIZE - 4, R1_BASE - 4, R1_BASE + R1_SIZE};
    start_test("boundaries");
    foreach (addrs[i]) begin
        reqs.push_back(make_req(1'b1, addrs[i], 32'h5E00_0000 | 32'(i), 4'hF));
    end
    burst_access(reqs);
    reqs.delete();
    foreach (addrs[i]) begin
        reqs.push_back(make_req(1'b0, addrs[i], '0, 4'hF));
    end
    burst_access(reqs);
    end_test();
endtask

task automatic pipelined_burst();
    dmem_pkg::wb_req_t reqs[$];
    start_test("pipelined_burst");
    reqs.push_back(make_req(1'b1, R0_BASE + 32'h20, 32'h0102_0304, 4'hF));
    reqs.push_back(make_req(1'b1, R1_BASE + 32'h20, 32'hF1F2_F3F4, 4'hF));
    reqs.push_back(make_req(1'b1, 32'h9000_0000, 32'h1234_5678, 4'hF));
    reqs.push_back(make_req(1'b0, R0_BASE + 32'h20, '0, 4'hF));
    reqs.push_back(make_req(1'b0, R1_BASE + 32'h20, '0, 4'hF));
    reqs.push_back(make_req(1'b0, 32'h9000_0000, '0, 4'hF));
    reqs.push_back(make_req(1'b1, R0_BASE + 32'h24, 32'h6666_7777, 4'hF));
    reqs.push_back(make_req(1'b0, R1_BASE + 32'h20, '0, 4'hF));
    reqs.push_back(make_req(1'b0, R0_BASE + 32'h24, '0, 4'hF));
    reqs.push_back(make_req(1'b0, 32'h8000_2000, '0, 4'hF));
    reqs.push_back(make_req(1'b0, R0_BASE + 32'h20, '0, 4'hF));
    burst_access(reqs);
    end_test();
endtask

// Address pool spread over both regions and the holes around them
function automatic logic [31:0] pool_addr(input int pick);
    if (pick < 16) begin
        return R0_BASE + 32'(pick) * 32'h100;
    end
    if (pick < 32) begin
        return R1_BASE + 32'(pick - 16) * 32'h1000 + 32'hFFC;
    end
    case (pick)
        32:      return 32'h0000_1000;
        33:      return 32'h7FFF_FFF0;
        34:      return 32'h8000_8000;
        default: return 32'h9000_0000;
    endcase
endfunction

task automatic random_traffic();
    logic [31:0] r;
    int          gap;
    start_test("random_traffic");
    // Fill the pool first so every later read has a known word
    for (int i = 0; i < 32; i++) begin
        bus_cycle(make_req(1'b1, pool_addr(i), lcg_next(), 4'hF));
    end
    for (int n = 0; n < RAND_COUNT; n++) begin
        r   = lcg_next();
        gap = int'(r[23:22]) % 3;
        bus_cycle(make_req(r[31], pool_addr(int'(r[21:14]) % 36), lcg_next(), r[27:24]));
        repeat (gap) bus_cycle('0);
    end
    bus_cycle('0);
    end_test();
endtask

//--- sim/tb_data_memory_subsystem.sv
`timescale 1ns/1ps

module tb_data_memory_subsystem;

    localparam int CLK_PERIOD_NS = 4;
    localparam int RESET_CYCLES  = 4;
    localparam int RAND_COUNT    = 200;

    // Region map as seen from the core
    localparam logic [31:0] R0_BASE = 32'h8000_0000;
    localparam logic [31:0] R0_SIZE = 32'h0000_1000;
    localparam logic [31:0] R1_BASE = 32'h8001_0000;
    localparam logic [31:0] R1_SIZE = 32'h0001_0000;

    // Data on every unmapped access
    localparam logic [31:0] UNMAPPED_DATA = 32'hDEAD_BEEF;

    // Cycles per test in run order
    // Random traffic takes at most three cycles per access
    localparam int TEST_CYCLES = RESET_CYCLES + 20 + 16 + 16 + 18 + 12 + 34 + RAND_COUNT * 3;
    localparam int TIMEOUT_NS  = TEST_CYCLES * CLK_PERIOD_NS * 2;

    logic              clk;
    logic              rst_n;
    dmem_pkg::wb_req_t core_req;
    dmem_pkg::wb_rsp_t core_rsp;

    // Reference memory keyed by absolute word address
    logic [31:0] ref_mem [logic [31:0]];

    // What the request of the previous cycle should bring back
    logic              pend_ack;
    logic              pend_check_dat;
    dmem_pkg::wb_rsp_t exp_rsp;

    logic [31:0] lcg_state;
    string       current_test;
    int          error_count;
    int          test_errors_at_start;
    int          tests_passed;
    int          tests_failed;

    data_memory_subsystem i_data_memory_subsystem (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_req_i (core_req),
        .core_rsp_o (core_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Error: watchdog expired after %0d ns, the DUT stopped answering", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic dmem_pkg::region_e expect_region(input logic [31:0] adr);
        if (adr >= R0_BASE && adr <= R0_BASE + R0_SIZE - 1) begin
            return dmem_pkg::REGION_0;
        end
        if (adr >= R1_BASE && adr <= R1_BASE + R1_SIZE - 1) begin
            return dmem_pkg::REGION_1;
        end
        return dmem_pkg::REGION_UNMAPPED;
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] adr);
        logic [31:0] key;
        key = {adr[31:2], 2'b00};
        if (ref_mem.exists(key)) begin
            return ref_mem[key];
        end
        return 'x;
    endfunction

    function automatic void model_write(input logic [31:0] adr, input logic [31:0] dat,
                                       input logic [3:0] sel);
        logic [31:0] word;
        word = model_read(adr);
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                word[8*b +: 8] = dat[8*b +: 8];
            end
        end
        ref_mem[{adr[31:2], 2'b00}] = word;
    endfunction

    // Sets the response due one cycle after req and updates the model on writes
    function automatic void predict(input dmem_pkg::wb_req_t req);
        dmem_pkg::region_e target;
        exp_rsp        = '0;
        pend_ack       = 1'b0;
        pend_check_dat = 1'b0;
        if (!(req.cyc && req.stb)) begin
            return;
        end
        target      = expect_region(req.adr);
        pend_ack    = 1'b1;
        exp_rsp.ack = 1'b1;
        if (target == dmem_pkg::REGION_UNMAPPED) begin
            exp_rsp.err    = 1'b1;
            exp_rsp.dat    = UNMAPPED_DATA;
            pend_check_dat = 1'b1;
        end else begin
            exp_rsp.dat    = model_read(req.adr);
            pend_check_dat = !req.we;
            if (req.we) begin
                model_write(req.adr, req.dat, req.sel);
            end
        end
    endfunction

    `include "tb_tasks.svh"

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        core_req             = '0;
        rst_n                = 1'b0;
        pend_ack             = 1'b0;
        pend_check_dat       = 1'b0;
        exp_rsp              = '0;
        lcg_state            = 32'd9552;
        current_test         = "reset";
        error_count          = 0;
        test_errors_at_start = 0;
        tests_passed         = 0;
        tests_failed         = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        region0_read_write();
        region_independence();
        unmapped_access();
        range_boundaries();
        pipelined_burst();
        random_traffic();

        $display("Summary: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- logic/data_memory_subsystem.sv
`timescale 1ns/1ps

module data_memory_subsystem #(
    parameter logic [dmem_pkg::ADDR_W-1:0] REGION0_BASE = 32'h8000_0000,
    parameter logic [dmem_pkg::ADDR_W-1:0] REGION0_SIZE = 32'h0000_1000,
    parameter logic [dmem_pkg::ADDR_W-1:0] REGION1_BASE = 32'h8001_0000,
    parameter logic [dmem_pkg::ADDR_W-1:0] REGION1_SIZE = 32'h0001_0000
) (
    input  logic              clk,
    input  logic              rst_n,

    // Core data port, pipelined Wishbone
    input  dmem_pkg::wb_req_t core_req_i,
    output dmem_pkg::wb_rsp_t core_rsp_o
);

    // Word depth of each SRAM
    localparam int REGION0_DEPTH = int'(REGION0_SIZE / 4);
    localparam int REGION1_DEPTH = int'(REGION1_SIZE / 4);

    dmem_pkg::wb_req_t region0_req;
    dmem_pkg::wb_rsp_t region0_rsp;
    dmem_pkg::wb_req_t region1_req;
    dmem_pkg::wb_rsp_t region1_rsp;

    //////////////////////////////
    // Address decoder
    //////////////////////////////

    data_memory_selector #(
        .REGION0_BASE (REGION0_BASE),
        .REGION0_SIZE (REGION0_SIZE),
        .REGION1_BASE (REGION1_BASE),
        .REGION1_SIZE (REGION1_SIZE)
    ) i_selector (
        .clk           (clk),
        .rst_n         (rst_n),
        .core_req_i    (core_req_i),
        .core_rsp_o    (core_rsp_o),
        .region0_req_o (region0_req),
        .region0_rsp_i (region0_rsp),
        .region1_req_o (region1_req),
        .region1_rsp_i (region1_rsp)
    );

    //////////////////////////////
    // Region memories
    //////////////////////////////

    // 4 KB
    wb_sram #(
        .DEPTH_WORDS (REGION0_DEPTH)
    ) i_region0_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (region0_req),
        .rsp_o (region0_rsp)
    );

    // 64 KB
    wb_sram #(
        .DEPTH_WORDS (REGION1_DEPTH)
    ) i_region1_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (region1_req),
        .rsp_o (region1_rsp)
    );

endmodule

//--- logic/data_memory_selector.sv
`timescale 1ns/1ps

module data_memory_selector #(
    parameter logic [dmem_pkg::ADDR_W-1:0] REGION0_BASE = 32'h8000_0000,
    parameter logic [dmem_pkg::ADDR_W-1:0] REGION0_SIZE = 32'h0000_1000,
    parameter logic [dmem_pkg::ADDR_W-1:0] REGION1_BASE = 32'h8001_0000,
    parameter logic [dmem_pkg::ADDR_W-1:0] REGION1_SIZE = 32'h0001_0000
) (
    input  logic              clk,
    input  logic              rst_n,

    // Core data port
    input  dmem_pkg::wb_req_t core_req_i,
    output dmem_pkg::wb_rsp_t core_rsp_o,

    // Region 0 memory
    output dmem_pkg::wb_req_t region0_req_o,
    input  dmem_pkg::wb_rsp_t region0_rsp_i,

    // Region 1 memory
    output dmem_pkg::wb_req_t region1_req_o,
    input  dmem_pkg::wb_rsp_t region1_rsp_i
);

    // Inclusive last byte address of each region
    localparam logic [dmem_pkg::ADDR_W-1:0] REGION0_LAST = REGION0_BASE + REGION0_SIZE - 1;
    localparam logic [dmem_pkg::ADDR_W-1:0] REGION1_LAST = REGION1_BASE + REGION1_SIZE - 1;

    logic core_accept;
    logic in_region0;
    logic in_region1;
    logic hit_region0;
    logic hit_region1;

    dmem_pkg::region_e target_d;
    dmem_pkg::region_e target_q;

    //////////////////////////////
    // Address decode
    //////////////////////////////

    assign core_accept = core_req_i.cyc && core_req_i.stb;

    always_comb begin
        in_region0 = (core_req_i.adr >= REGION0_BASE) && (core_req_i.adr <= REGION0_LAST);
        in_region1 = (core_req_i.adr >= REGION1_BASE) && (core_req_i.adr <= REGION1_LAST);
    end

    // Region 0 wins if the two ranges ever overlap
    assign hit_region0 = in_region0;
    assign hit_region1 = in_region1 && !in_region0;

    //////////////////////////////
    // Request routing
    //////////////////////////////

    // Forward to one slave with the address rebased, or drive an idle request
    function automatic dmem_pkg::wb_req_t route_req(
        input dmem_pkg::wb_req_t               req,
        input logic                            hit,
        input logic [dmem_pkg::ADDR_W-1:0]     base
    );
        dmem_pkg::wb_req_t fwd;
        fwd = '0;
        if (hit) begin
            fwd     = req;
            fwd.adr = req.adr - base;
        end
        return fwd;
    endfunction

    always_comb begin
        region0_req_o = route_req(core_req_i, hit_region0, REGION0_BASE);
        region1_req_o = route_req(core_req_i, hit_region1, REGION1_BASE);
    end

    //////////////////////////////
    // Response steering
    //////////////////////////////

    // Where this cycle's request goes, if there is one
    always_comb begin
        if (!core_accept) begin
            target_d = dmem_pkg::REGION_NONE;
        end else if (hit_region0) begin
            target_d = dmem_pkg::REGION_0;
        end else if (hit_region1) begin
            target_d = dmem_pkg::REGION_1;
        end else begin
            target_d = dmem_pkg::REGION_UNMAPPED;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            target_q <= dmem_pkg::REGION_NONE;
        end else begin
            target_q <= target_d;
        end
    end

    // One response per cycle picked by last cycle's target
    always_comb begin
        case (target_q)
            dmem_pkg::REGION_0: begin
                core_rsp_o = region0_rsp_i;
            end
            dmem_pkg::REGION_1: begin
                core_rsp_o = region1_rsp_i;
            end
            dmem_pkg::REGION_UNMAPPED: begin
                // Decoder answers itself since no slave saw the request
                core_rsp_o.ack = 1'b1;
                core_rsp_o.err = 1'b1;
                core_rsp_o.dat = dmem_pkg::ERR_DATA;
            end
            default: begin
                core_rsp_o = '0;
            end
        endcase
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // At most one slave is strobed per cycle
    region_stb_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(region0_req_o.stb && region1_req_o.stb)
    ) else $error("both region strobes high");

    // Slave or decoder answers every accepted request on the next cycle
    ack_after_accept: assert property (
        @(posedge clk) disable iff (!rst_n)
        core_accept |=> core_rsp_o.ack
    ) else $error("missing ack one cycle after accepted request");

endmodule

//--- logic/wb_sram.sv
`timescale 1ns/1ps

module wb_sram #(
    parameter int DEPTH_WORDS = 1024
) (
    input  logic              clk,
    input  logic              rst_n,

    // Local byte address from the selector
    input  dmem_pkg::wb_req_t req_i,
    output dmem_pkg::wb_rsp_t rsp_o
);

    localparam int IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;

    logic             req_accept;
    logic             wr_en;
    logic [IDX_W-1:0] word_idx;

    logic                        ack_q;
    logic [dmem_pkg::DATA_W-1:0] rd_data_q;

    // Storage, one entry per bus word
    logic [dmem_pkg::DATA_W-1:0] mem_q [DEPTH_WORDS];

    //////////////////////////////
    // Request decode
    //////////////////////////////

    assign req_accept = req_i.cyc && req_i.stb;
    assign wr_en      = req_accept && req_i.we;

    // Byte address to word index, low two bits dropped
    assign word_idx = req_i.adr[IDX_W+1:2];

    //////////////////////////////
    // Array
    //////////////////////////////

    // Byte lanes written under sel
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < dmem_pkg::SEL_W; b++) begin
                if (req_i.sel[b]) begin
                    mem_q[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
                end
            end
        end
    end

    // Old word comes back on writes as well as reads
    always_ff @(posedge clk) begin
        if (req_accept) begin
            rd_data_q <= mem_q[word_idx];
        end
    end

    //////////////////////////////
    // Acknowledge
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_accept;
        end
    end

    always_comb begin
        rsp_o.ack = ack_q;
        // An SRAM has no failing access
        rsp_o.err = 1'b0;
        rsp_o.dat = rd_data_q;
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Region size in the selector keeps every access inside the array
    index_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_accept |-> (req_i.adr[dmem_pkg::ADDR_W-1:2] < DEPTH_WORDS)
    ) else $error("word index 0x%0h beyond depth %0d",
                  req_i.adr[dmem_pkg::ADDR_W-1:2], DEPTH_WORDS);

endmodule

//--- logic/dmem_pkg.sv
package dmem_pkg;

    //////////////////////////////
    // Bus widths
    //////////////////////////////

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;

    // Read data returned for accesses outside every region
    localparam logic [DATA_W-1:0] ERR_DATA = 32'hDEAD_BEEF;

    //////////////////////////////
    // Wishbone payloads
    //////////////////////////////

    // Master side, 71 bits
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic [SEL_W-1:0]  sel;
    } wb_req_t;

    // Slave side, 34 bits
    typedef struct packed {
        logic              ack;
        logic              err;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

    //////////////////////////////
    // Response routing
    //////////////////////////////

    // Target of the request accepted in the previous cycle
    typedef enum logic [1:0] {
        REGION_NONE     = 2'd0,
        REGION_0        = 2'd1,
        REGION_1        = 2'd2,
        REGION_UNMAPPED = 2'd3
    } region_e;

endpackage
